// File: timer_pkg.sv
/*
 * Timer shared definitions
 * Bus widths, register map, vector types and the structs between blocks
 */
`default_nettype none

package timer_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    typedef logic [AXI_ADDR_W-1:0] addr_t;
    typedef logic [AXI_DATA_W-1:0] data_t;
    typedef logic [AXI_STRB_W-1:0] strb_t;
    typedef logic [31:0]           count_t;
    typedef logic [1:0]            resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // ------------------------------------------------------------------
    // Register map, byte offsets
    // ------------------------------------------------------------------
    localparam addr_t REG_CTRL   = 32'h0000_0000;
    localparam addr_t REG_LOAD   = 32'h0000_0004;
    localparam addr_t REG_COUNT  = 32'h0000_0008;
    localparam addr_t REG_STATUS = 32'h0000_000C;

    // Field order puts enable at bit 0 of CTRL
    typedef struct packed {
        logic irq_en;
        logic auto_reload;
        logic enable;
    } timer_ctrl_t;

    // Native register bus, single-cycle strobes
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t be;
        logic  we;
        logic  re;
    } reg_bus_req_t;

endpackage

`default_nettype wire

// File: axi4lite_slave_adapter.sv
/*
 * AXI4-Lite slave adapter
 * Turns AXI4-Lite write and read handshakes into single-cycle native
 * register strobes, one transaction per direction at a time
 */
`timescale 1ns/10ps
`default_nettype none

module axi4lite_slave_adapter import timer_pkg::*; (
    input  logic         aclk,
    input  logic         aresetn,

    // Write address channel
    input  addr_t        s_axi_awaddr,
    input  logic [2:0]   s_axi_awprot,
    input  logic         s_axi_awvalid,
    output logic         s_axi_awready,

    // Write data channel
    input  data_t        s_axi_wdata,
    input  strb_t        s_axi_wstrb,
    input  logic         s_axi_wvalid,
    output logic         s_axi_wready,

    // Write response channel
    output resp_t        s_axi_bresp,
    output logic         s_axi_bvalid,
    input  logic         s_axi_bready,

    // Read address channel
    input  addr_t        s_axi_araddr,
    input  logic [2:0]   s_axi_arprot,
    input  logic         s_axi_arvalid,
    output logic         s_axi_arready,

    // Read data channel
    output data_t        s_axi_rdata,
    output resp_t        s_axi_rresp,
    output logic         s_axi_rvalid,
    input  logic         s_axi_rready,

    // Native register bus
    output reg_bus_req_t reg_req,
    input  data_t        reg_rdata
);

    // Protection bits on awprot and arprot carry no meaning for this slave

    logic wr_accept_q;
    logic wr_busy_q;
    logic rd_accept_q;
    logic wr_go;
    logic rd_go;
    logic wr_strobe;
    logic rd_strobe;

    // ------------------------------------------------------------------
    // Accept decisions, write wins a tie so strobes never overlap
    // ------------------------------------------------------------------
    assign wr_go = !wr_accept_q && !wr_busy_q && s_axi_awvalid && s_axi_wvalid;
    assign rd_go = !rd_accept_q && !s_axi_rvalid && s_axi_arvalid && !wr_go;

    // Write path
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_accept_q  <= 1'b0;
            wr_busy_q    <= 1'b0;
            s_axi_bvalid <= 1'b0;
        end else begin
            wr_accept_q <= wr_go;
            if (wr_go) begin
                wr_busy_q <= 1'b1;
            end else if (s_axi_bvalid && s_axi_bready) begin
                wr_busy_q <= 1'b0;
            end
            // Response follows the accept cycle and waits for bready
            if (wr_strobe) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    // Read path
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_accept_q  <= 1'b0;
            s_axi_rvalid <= 1'b0;
        end else begin
            rd_accept_q <= rd_go;
            if (rd_strobe) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    assign s_axi_awready = wr_accept_q;
    assign s_axi_wready  = wr_accept_q;
    assign s_axi_arready = rd_accept_q;

    // Always OKAY
    assign s_axi_bresp = RESP_OKAY;
    assign s_axi_rresp = RESP_OKAY;

    // ------------------------------------------------------------------
    // Native bus
    // ------------------------------------------------------------------
    assign wr_strobe = wr_accept_q && s_axi_awvalid && s_axi_wvalid;
    assign rd_strobe = rd_accept_q && s_axi_arvalid;

    always_comb begin
        reg_req.we    = wr_strobe;
        reg_req.re    = rd_strobe;
        reg_req.addr  = wr_strobe ? s_axi_awaddr : s_axi_araddr;
        reg_req.wdata = s_axi_wdata;
        reg_req.be    = s_axi_wstrb;
    end

    // Register block holds the value latched on re
    assign s_axi_rdata = reg_rdata;

    a_no_we_re_overlap: assert property (@(posedge aclk) disable iff (!aresetn)
        !(reg_req.we && reg_req.re));

    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

endmodule

`default_nettype wire

// File: timer_regs.sv
/*
 * Timer register block
 * Decodes the native bus into CTRL, LOAD, COUNT and STATUS, steers the
 * timer core and raises the interrupt
 */
`timescale 1ns/10ps
`default_nettype none

module timer_regs import timer_pkg::*; (
    input  logic         aclk,
    input  logic         aresetn,
    input  reg_bus_req_t reg_req,
    output data_t        reg_rdata,
    input  count_t       count,
    input  logic         expire,
    output timer_ctrl_t  ctrl,
    output count_t       load_value,
    output logic         load_strobe,
    output logic         irq
);

    timer_ctrl_t ctrl_q;
    count_t      load_q;
    logic        load_strobe_q;
    logic        expired_q;
    data_t       rdata_q;
    addr_t       word_addr;
    data_t       ctrl_wr;
    data_t       load_wr;
    logic        wr_ctrl;
    logic        wr_load;
    logic        wr_status;

    // Byte-wise merge of a write into the old register value
    function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                          input strb_t be);
        data_t result;
        result = old_val;
        for (int i = 0; i < AXI_STRB_W; i++) begin
            if (be[i]) begin
                result[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return result;
    endfunction

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    assign word_addr = {reg_req.addr[AXI_ADDR_W-1:2], 2'b00};
    assign wr_ctrl   = reg_req.we && (word_addr == REG_CTRL);
    assign wr_load   = reg_req.we && (word_addr == REG_LOAD);
    assign wr_status = reg_req.we && (word_addr == REG_STATUS);

    assign ctrl_wr = merge_bytes(data_t'(ctrl_q), reg_req.wdata, reg_req.be);
    assign load_wr = merge_bytes(load_q, reg_req.wdata, reg_req.be);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ctrl_q        <= '0;
            load_q        <= '0;
            load_strobe_q <= 1'b0;
            expired_q     <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                ctrl_q <= ctrl_wr[$bits(timer_ctrl_t)-1:0];
            end
            // One-shot mode stops the timer on expiry
            if (expire && !ctrl_q.auto_reload) begin
                ctrl_q.enable <= 1'b0;
            end
            if (wr_load) begin
                load_q <= load_wr;
            end
            // Core picks up the new LOAD one cycle after the write
            load_strobe_q <= wr_load;
            // Set beats write-1-to-clear
            if (expire) begin
                expired_q <= 1'b1;
            end else if (wr_status && reg_req.be[0] && reg_req.wdata[0]) begin
                expired_q <= 1'b0;
            end
        end
    end

    // Read data captured on the re strobe
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rdata_q <= '0;
        end else if (reg_req.re) begin
            case (word_addr)
                REG_CTRL:   rdata_q <= data_t'(ctrl_q);
                REG_LOAD:   rdata_q <= load_q;
                REG_COUNT:  rdata_q <= count;
                REG_STATUS: rdata_q <= data_t'(expired_q);
                default:    rdata_q <= '0;
            endcase
        end
    end

    assign reg_rdata   = rdata_q;
    assign ctrl        = ctrl_q;
    assign load_value  = load_q;
    assign load_strobe = load_strobe_q;
    assign irq         = expired_q && ctrl_q.irq_en;

    // irq only rises after a core expiry or a CTRL write, and needs expired
    a_irq_source: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(irq) |-> expired_q && ($past(expire) || $past(reg_req.we)));

endmodule

`default_nettype wire

// File: timer_core.sv
/*
 * Timer core
 * Countdown counter with load, enable and auto-reload, pulses expire
 * for one cycle when an enabled count reaches zero
 */
`timescale 1ns/10ps
`default_nettype none

module timer_core import timer_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    input  timer_ctrl_t ctrl,
    input  count_t      load_value,
    input  logic        load_strobe,
    output count_t      count,
    output logic        expire
);

    count_t count_q;

    // ------------------------------------------------------------------
    // Counter
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count_q <= '0;
        end else if (load_strobe) begin
            count_q <= load_value;
        end else if (ctrl.enable) begin
            if (count_q != '0) begin
                count_q <= count_q - 1'b1;
            end else if (ctrl.auto_reload) begin
                // Zero cycle counts, so period is load_value + 1
                count_q <= load_value;
            end
        end
    end

    assign expire = ctrl.enable && (count_q == '0);
    assign count  = count_q;

    // Relies on the register block dropping enable in one-shot mode
    a_expire_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        expire && !(ctrl.auto_reload && load_value == '0) |=> !expire);

endmodule

`default_nettype wire

// File: axi_timer_top.sv
/*
 * AXI4-Lite countdown timer
 * Bus adapter, register block and countdown core with interrupt output
 */
`timescale 1ns/10ps
`default_nettype none

module axi_timer_top import timer_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  addr_t      s_axi_awaddr,
    input  logic [2:0] s_axi_awprot,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    input  data_t      s_axi_wdata,
    input  strb_t      s_axi_wstrb,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,
    output resp_t      s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    input  addr_t      s_axi_araddr,
    input  logic [2:0] s_axi_arprot,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    output data_t      s_axi_rdata,
    output resp_t      s_axi_rresp,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready,
    output logic       irq
);

    reg_bus_req_t reg_req;
    data_t        reg_rdata;
    timer_ctrl_t  ctrl;
    count_t       load_value;
    logic         load_strobe;
    count_t       count;
    logic         expire;

    axi4lite_slave_adapter u_adapter (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awprot  (s_axi_awprot),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arprot  (s_axi_arprot),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .reg_req       (reg_req),
        .reg_rdata     (reg_rdata)
    );

    timer_regs u_regs (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .reg_req     (reg_req),
        .reg_rdata   (reg_rdata),
        .count       (count),
        .expire      (expire),
        .ctrl        (ctrl),
        .load_value  (load_value),
        .load_strobe (load_strobe),
        .irq         (irq)
    );

    timer_core u_core (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .ctrl        (ctrl),
        .load_value  (load_value),
        .load_strobe (load_strobe),
        .count       (count),
        .expire      (expire)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset source
 * 10 ns clock, reset held low for five cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Release on a falling edge, like every other input
    initial begin
        aresetn = 1'b0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_axi_timer.sv
/*
 * Testbench for the AXI4-Lite countdown timer
 * Replays a trace of bus writes, reads and irq waits against the DUT
 */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_timer import timer_pkg::*; ();

    localparam int HANDSHAKE_TIMEOUT = 50;
    localparam int IRQ_TIMEOUT       = 500;
    localparam int RESET_TIMEOUT     = 20;
    localparam int RREADY_DELAY      = 3;

    logic       aclk;
    logic       aresetn;
    addr_t      awaddr;
    logic [2:0] awprot;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;
    resp_t      bresp;
    logic       bvalid;
    logic       bready;
    addr_t      araddr;
    logic [2:0] arprot;
    logic       arvalid;
    logic       arready;
    data_t      rdata;
    resp_t      rresp;
    logic       rvalid;
    logic       rready;
    logic       irq;

    tb_clock_gen u_clock (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    axi_timer_top uut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_axi_awaddr  (awaddr),
        .s_axi_awprot  (awprot),
        .s_axi_awvalid (awvalid),
        .s_axi_awready (awready),
        .s_axi_wdata   (wdata),
        .s_axi_wstrb   (wstrb),
        .s_axi_wvalid  (wvalid),
        .s_axi_wready  (wready),
        .s_axi_bresp   (bresp),
        .s_axi_bvalid  (bvalid),
        .s_axi_bready  (bready),
        .s_axi_araddr  (araddr),
        .s_axi_arprot  (arprot),
        .s_axi_arvalid (arvalid),
        .s_axi_arready (arready),
        .s_axi_rdata   (rdata),
        .s_axi_rresp   (rresp),
        .s_axi_rvalid  (rvalid),
        .s_axi_rready  (rready),
        .irq           (irq)
    );

    // ------------------------------------------------------------------
    // Failure handling and compare tasks
    // ------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h",
                                $time, name, expected, actual));
        end
    endtask

    // Running count is only known to lie inside a window
    task automatic check_range(input string name, input data_t low, input data_t high,
                               input data_t actual);
        if (actual < low || actual > high) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected %h..%h got %h",
                                $time, name, low, high, actual));
        end
    endtask

    task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_irq(input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t ns: irq expected %b got %b",
                                $time, expected, actual));
        end
    endtask

    // ------------------------------------------------------------------
    // AXI4-Lite master, every task starts and ends on a falling edge
    // ------------------------------------------------------------------
    task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb);
        int cycles;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cycles  = 0;
        while (!(awready && wready)) begin
            @(negedge aclk);
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                abort_run("Timed out waiting for awready and wready");
            end
        end
        // Handshake completes at the next rising edge
        @(negedge aclk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cycles  = 0;
        while (!bvalid) begin
            @(negedge aclk);
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                abort_run("Timed out waiting for bvalid");
            end
        end
        check_resp("bresp", RESP_OKAY, bresp);
        bready = 1'b1;
        @(negedge aclk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output data_t data);
        int cycles;
        araddr  = addr;
        arvalid = 1'b1;
        cycles  = 0;
        while (!arready) begin
            @(negedge aclk);
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                abort_run("Timed out waiting for arready");
            end
        end
        @(negedge aclk);
        arvalid = 1'b0;
        cycles  = 0;
        // rready stays low a while, so rdata must hold under back-pressure
        while (!rvalid) begin
            @(negedge aclk);
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                abort_run("Timed out waiting for rvalid");
            end
        end
        repeat (RREADY_DELAY) begin
            @(negedge aclk);
            if (rvalid !== 1'b1) begin
                abort_run("rvalid dropped while rready was still low");
            end
        end
        data = rdata;
        check_resp("rresp", RESP_OKAY, rresp);
        rready = 1'b1;
        @(negedge aclk);
        rready = 1'b0;
    endtask

    // Wait for an irq level, then require it to hold for some cycles
    task automatic wait_irq(input logic level, input data_t hold);
        int cycles;
        cycles = 0;
        while (irq !== level) begin
            @(negedge aclk);
            cycles++;
            if (cycles > IRQ_TIMEOUT) begin
                abort_run($sformatf("Timed out waiting for irq to go %b", level));
            end
        end
        repeat (hold) begin
            @(negedge aclk);
            check_irq(level, irq);
        end
    endtask

    task automatic run_op(input string op, input addr_t addr, input data_t data,
                          input strb_t strb, input data_t expected, input int line_no);
        data_t value;
        string name;
        name = $sformatf("rdata @ %h (trace line %0d)", addr, line_no);
        if (op == "W") begin
            axi_write(addr, data, strb);
        end else if (op == "R") begin
            axi_read(addr, value);
            check_data(name, expected, value);
        end else if (op == "RR") begin
            axi_read(addr, value);
            check_range(name, data, expected, value);
        end else if (op == "I") begin
            wait_irq(1'b1, data);
        end else if (op == "Q") begin
            wait_irq(1'b0, data);
        end else begin
            abort_run($sformatf("Unknown operation %s on trace line %0d", op, line_no));
        end
    endtask

    // ------------------------------------------------------------------
    // Trace replay
    // ------------------------------------------------------------------
    initial begin
        int    fd;
        int    fields;
        int    line_no;
        int    cycles;
        string line;
        string op;
        addr_t addr;
        data_t data;
        strb_t strb;
        data_t expected;

        awaddr  = '0;
        awprot  = 3'b000;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arprot  = 3'b000;
        arvalid = 1'b0;
        rready  = 1'b0;

        fd = $fopen("axi_timer_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file axi_timer_trace.txt");
        end

        cycles = 0;
        while (aresetn !== 1'b1) begin
            @(negedge aclk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                abort_run("Timed out waiting for reset release");
            end
        end
        @(negedge aclk);
        check_irq(1'b0, irq);

        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            // Comment and blank lines carry no operation
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %h %h %h", op, addr, data, strb, expected);
                if (fields != 5) begin
                    abort_run($sformatf("Trace line %0d is malformed", line_no));
                end
                run_op(op, addr, data, strb, expected, line_no);
            end
        end
        $fclose(fd);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: axi_timer_trace.txt
# op addr data strb expected, all hex; W write, R read and compare, RR read within data..expected
# I and Q wait for irq high or low, then hold that level for data cycles
R 00000008 00000000 0 00000000
R 00000010 00000000 0 00000000
W 00000010 ffffffff f 00000000
W 00000008 12345678 f 00000000
R 00000010 00000000 0 00000000
R 00000008 00000000 0 00000000
R 00000000 00000000 0 00000000
W 00000004 12345678 f 00000000
R 00000004 00000000 0 12345678
W 00000004 aabbccdd 5 00000000
R 00000004 00000000 0 12bb56dd
W 00000004 0000ff00 2 00000000
R 00000004 00000000 0 12bbffdd
W 00000000 00000006 e 00000000
R 00000000 00000000 0 00000000
W 00000000 00000006 1 00000000
R 00000000 00000000 0 00000006
# one-shot with interrupt enabled
W 00000004 00000010 f 00000000
W 00000000 00000005 f 00000000
I 00000000 00000000 0 00000000
R 00000000 00000000 0 00000004
R 0000000c 00000000 0 00000001
W 0000000c 00000001 f 00000000
Q 00000000 00000000 0 00000000
R 0000000c 00000000 0 00000000
# auto-reload, irq comes back after clearing
W 00000004 00000020 f 00000000
W 00000000 00000007 f 00000000
RR 00000008 00000000 0 00000020
I 00000000 00000000 0 00000000
W 0000000c 00000001 f 00000000
Q 00000000 00000000 0 00000000
I 00000000 00000000 0 00000000
W 00000000 00000000 f 00000000
W 0000000c 00000001 f 00000000
R 0000000c 00000000 0 00000000
# one-shot with interrupt disabled
W 00000004 00000002 f 00000000
W 00000000 00000001 f 00000000
RR 00000008 00000000 0 00000002
R 0000000c 00000000 0 00000001
Q 00000020 00000000 0 00000000
R 00000000 00000000 0 00000000

// File: project.f
timer_pkg.sv
axi4lite_slave_adapter.sv
timer_regs.sv
timer_core.sv
axi_timer_top.sv
tb_clock_gen.sv
tb_axi_timer.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		-f project.f --top-module tb_axi_timer -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "^Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
